// ==== verilog/mem_pkg.sv ====
package mem_pkg;

	// Core access opcodes
	typedef enum logic [3:0] {
		MEM_NONE = 4'd0,
		MEM_LB   = 4'd1,
		MEM_LBU  = 4'd2,
		MEM_LH   = 4'd3,
		MEM_LHU  = 4'd4,
		MEM_LW   = 4'd5,
		MEM_SB   = 4'd6,
		MEM_SH   = 4'd7,
		MEM_SW   = 4'd8
	} mem_op_e;

	// Request from the core, one per cycle
	typedef struct packed {
		mem_op_e     op;
		// Byte address
		logic [12:0] addr;
		// Narrow stores keep their value in the low bits
		logic [31:0] wdata;
	} core_req_t;

	// Aligned core access
	typedef struct packed {
		// Zero for loads and idle
		logic [3:0]  lanes;
		logic [10:0] word;
		// Already shifted into lanes
		logic [31:0] data;
	} mem_wr_t;

	// Protocol controller port
	typedef struct packed {
		logic [3:0]  lanes;
		// RAM word address
		logic [9:0]  addr;
		logic [31:0] data;
	} con_req_t;

	// Board inputs
	typedef struct packed {
		logic [3:0] btn;
		logic [2:0] sw;
	} io_in_t;

	// RAM depth in words
	localparam int RAM_WORDS = 1024;

	// I/O word addresses
	localparam logic [10:0] IO_BTN_WORD = 11'h400;
	localparam logic [10:0] IO_SW_WORD  = 11'h401;
	localparam logic [10:0] IO_LED_WORD = 11'h402;

	// LED pins driven from the LED register
	localparam int LED_PINS = 4;

endpackage

// ==== verilog/byte_ram.sv ====
`timescale 1ns/100ps

module byte_ram (
	input  logic        clk,
	// Port A
	input  logic [3:0]  a_lanes,
	input  logic [9:0]  a_addr,
	input  logic [31:0] a_wdata,
	output logic [31:0] a_rdata,
	// Port B
	input  logic [3:0]  b_lanes,
	input  logic [9:0]  b_addr,
	input  logic [31:0] b_wdata,
	output logic [31:0] b_rdata
);
	import mem_pkg::*;

	// Storage, contents not reset
	logic [31:0] mem [0:RAM_WORDS-1];

	// Port A, byte writes with read-first output
	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (a_lanes[i]) begin
				mem[a_addr][i*8 +: 8] <= a_wdata[i*8 +: 8];
			end
			// Same-word collisions with port A are undefined
			if (b_lanes[i]) begin
				mem[b_addr][i*8 +: 8] <= b_wdata[i*8 +: 8];
			end
		end
	end

	// Old word captured on the write edge
	always_ff @(posedge clk) begin
		a_rdata <= mem[a_addr];
	end

	// Port B read, also read-first
	always_ff @(posedge clk) begin
		b_rdata <= mem[b_addr];
	end

endmodule

// ==== verilog/io_regs.sv ====
`timescale 1ns/100ps

module io_regs (
	input  logic                         clk,
	input  logic                         reset,
	input  mem_pkg::io_in_t              io_in,
	input  logic [10:0]                  word,
	input  logic [3:0]                   lanes,
	input  logic [31:0]                  wdata,
	output logic [31:0]                  rdata,
	output logic [mem_pkg::LED_PINS-1:0] led
);
	import mem_pkg::*;

	// Sampled inputs, zero-extended
	logic [31:0] btn_reg;
	logic [31:0] sw_reg;

	logic [31:0] led_reg;
	logic        led_wr;

	// Combinational read value before the output register
	logic [31:0] rd_next;

	// Buttons and switches sampled on every edge
	always_ff @(posedge clk) begin
		if (reset) begin
			btn_reg <= 32'h00000000;
			sw_reg  <= 32'h00000000;
		end else begin
			btn_reg <= {28'h0000000, io_in.btn};
			sw_reg  <= {29'h00000000, io_in.sw};
		end
	end

	assign led_wr = (word == IO_LED_WORD);

	// LED register merges enabled bytes
	always_ff @(posedge clk) begin
		if (reset) begin
			led_reg <= 32'h00000000;
		end else if (led_wr) begin
			for (int i = 0; i < 4; i++) begin
				if (lanes[i]) begin
					led_reg[i*8 +: 8] <= wdata[i*8 +: 8];
				end
			end
		end
	end

	assign led = led_reg[LED_PINS-1:0];

	// Unmapped I/O words read as zero
	always_comb begin
		case (word)
			IO_BTN_WORD: rd_next = btn_reg;
			IO_SW_WORD:  rd_next = sw_reg;
			IO_LED_WORD: rd_next = led_reg;
			default:     rd_next = 32'h00000000;
		endcase
	end

	// Registered like the RAM output
	always_ff @(posedge clk) begin
		rdata <= rd_next;
	end

endmodule

// ==== verilog/lsu_align.sv ====
`timescale 1ns/100ps

module lsu_align (
	input  logic               clk,
	input  logic               reset,
	input  mem_pkg::core_req_t req,
	output mem_pkg::mem_wr_t   acc,
	input  logic [31:0]        rd_word,
	output logic [31:0]        ld_data,
	output logic               ld_valid
);
	import mem_pkg::*;

	// Byte offset inside the word
	logic [1:0] req_off;
	logic       req_load;

	// Load held over for the result cycle
	mem_op_e    ld_op_q;
	logic [1:0] ld_off_q;

	// Pieces of the returned word
	logic [7:0]  ld_byte;
	logic [15:0] ld_half;

	assign req_off = req.addr[1:0];

	always_comb begin
		case (req.op)
			MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW: req_load = 1'b1;
			default: req_load = 1'b0;
		endcase
	end

	// Word address, store lanes and replicated data
	always_comb begin
		// Word address drops the two offset bits
		acc.word  = req.addr[12:2];
		acc.lanes = 4'b0000;
		acc.data  = req.wdata;
		case (req.op)
			MEM_SB: begin
				acc.lanes = 4'b0001 << req_off;
				acc.data  = {4{req.wdata[7:0]}};
			end
			MEM_SH: begin
				// Halfword lanes follow bit 1 only
				acc.lanes = req_off[1] ? 4'b1100 : 4'b0011;
				acc.data  = {2{req.wdata[15:0]}};
			end
			MEM_SW: begin
				acc.lanes = 4'b1111;
			end
			default: begin
				acc.lanes = 4'b0000;
			end
		endcase
	end

	// Only loads go forward to the result cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			ld_op_q <= MEM_NONE;
		end else if (req_load) begin
			ld_op_q <= req.op;
		end else begin
			ld_op_q <= MEM_NONE;
		end
	end

	always_ff @(posedge clk) begin
		ld_off_q <= req_off;
	end

	// Addressed byte and halfword of the read word
	assign ld_byte = rd_word[ld_off_q*8 +: 8];
	assign ld_half = ld_off_q[1] ? rd_word[31:16] : rd_word[15:0];

	// Sign or zero extension
	always_comb begin
		case (ld_op_q)
			MEM_LB:  ld_data = {{24{ld_byte[7]}}, ld_byte};
			MEM_LBU: ld_data = {24'h000000, ld_byte};
			MEM_LH:  ld_data = {{16{ld_half[15]}}, ld_half};
			MEM_LHU: ld_data = {16'h0000, ld_half};
			MEM_LW:  ld_data = rd_word;
			default: ld_data = 32'h00000000;
		endcase
	end

	// One pulse per load
	assign ld_valid = (ld_op_q != MEM_NONE);

endmodule

// ==== verilog/datamem.sv ====
`timescale 1ns/100ps

module datamem (
	input  logic                         clk,
	input  logic                         reset,
	input  mem_pkg::mem_wr_t             acc,
	input  mem_pkg::con_req_t            con,
	input  mem_pkg::io_in_t              io_in,
	output logic [31:0]                  rd_word,
	output logic [31:0]                  con_rdata,
	output logic [mem_pkg::LED_PINS-1:0] led
);
	import mem_pkg::*;

	// Region of the current core access
	logic        ram_sel;
	// Region of last cycle's access
	logic        ram_sel_q;

	// Lanes per block after decode
	logic [3:0]  ram_lanes;
	logic [3:0]  io_lanes;

	logic [31:0] ram_rdata;
	logic [31:0] io_rdata;

	// Words below the RAM depth are RAM, the rest is I/O space
	assign ram_sel = (acc.word < RAM_WORDS);

	assign ram_lanes = ram_sel ? acc.lanes : 4'b0000;
	assign io_lanes  = ram_sel ? 4'b0000 : acc.lanes;

	// Core on port A, controller on port B
	byte_ram ram0 (
		.clk     (clk),
		.a_lanes (ram_lanes),
		.a_addr  (acc.word[9:0]),
		.a_wdata (acc.data),
		.a_rdata (ram_rdata),
		.b_lanes (con.lanes),
		.b_addr  (con.addr),
		.b_wdata (con.data),
		.b_rdata (con_rdata)
	);

	// Buttons, switches and LEDs
	io_regs io0 (
		.clk   (clk),
		.reset (reset),
		.io_in (io_in),
		.word  (acc.word),
		.lanes (io_lanes),
		.wdata (acc.data),
		.rdata (io_rdata),
		.led   (led)
	);

	// Select follows the data by one cycle
	always_ff @(posedge clk) begin
		if (reset) begin
			ram_sel_q <= 1'b0;
		end else begin
			ram_sel_q <= ram_sel;
		end
	end

	// Both sources are registered already
	assign rd_word = ram_sel_q ? ram_rdata : io_rdata;

endmodule

// ==== verilog/mem_subsys.sv ====
`timescale 1ns/100ps

module mem_subsys (
	input  logic                         clk,
	input  logic                         reset,
	input  mem_pkg::core_req_t           req,
	input  mem_pkg::con_req_t            con,
	input  mem_pkg::io_in_t              io_in,
	output logic [31:0]                  ld_data,
	output logic                         ld_valid,
	output logic [31:0]                  con_rdata,
	output logic [mem_pkg::LED_PINS-1:0] led
);
	import mem_pkg::*;

	// Aligned access into the memory
	mem_wr_t     acc;
	// Word read in the previous cycle
	logic [31:0] rd_word;

	// Request alignment and load extraction
	lsu_align align0 (
		.clk      (clk),
		.reset    (reset),
		.req      (req),
		.acc      (acc),
		.rd_word  (rd_word),
		.ld_data  (ld_data),
		.ld_valid (ld_valid)
	);

	// RAM and memory-mapped I/O
	datamem dmem0 (
		.clk       (clk),
		.reset     (reset),
		.acc       (acc),
		.con       (con),
		.io_in     (io_in),
		.rd_word   (rd_word),
		.con_rdata (con_rdata),
		.led       (led)
	);

endmodule

// ==== sim/mem_subsys_chk.sv ====
`timescale 1ns/100ps

module mem_subsys_chk (
	input  logic                         clk,
	input  logic                         reset,
	input  mem_pkg::core_req_t           req,
	input  mem_pkg::mem_wr_t             acc,
	input  logic                         ld_valid,
	input  logic [mem_pkg::LED_PINS-1:0] led
);
	import mem_pkg::*;

	// Lane patterns each opcode may produce
	function automatic logic lanes_ok(input mem_op_e op, input logic [3:0] lanes);
		case (op)
			MEM_SB:  return lanes inside {4'b0001, 4'b0010, 4'b0100, 4'b1000};
			MEM_SH:  return lanes inside {4'b0011, 4'b1100};
			MEM_SW:  return lanes == 4'b1111;
			default: return lanes == 4'b0000;
		endcase
	endfunction

	function automatic logic is_load(input mem_op_e op);
		return op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
	endfunction

	// Result pulse only in the cycle after a load
	valid_needs_load: assert property (@(posedge clk) disable iff (reset)
		ld_valid |-> $past(is_load(req.op)))
		else $error("ld_valid high without a load in the previous cycle");

	// Every load gives its pulse
	load_gives_valid: assert property (@(posedge clk) disable iff (reset)
		is_load(req.op) |=> ld_valid)
		else $error("load not followed by ld_valid");

	lanes_match_op: assert property (@(posedge clk) disable iff (reset)
		lanes_ok(req.op, acc.lanes))
		else $error("acc lanes not allowed for the opcode");

	// LEDs dark once reset has been seen
	led_clear_after_reset: assert property (@(posedge clk)
		reset |=> (led == '0))
		else $error("led not zero after reset");

endmodule

bind mem_subsys mem_subsys_chk chk0 (
	.clk      (clk),
	.reset    (reset),
	.req      (req),
	.acc      (acc),
	.ld_valid (ld_valid),
	.led      (led)
);

// ==== sim/mem_subsys_tb.sv ====
`timescale 1ns/100ps

module mem_subsys_tb;
	import mem_pkg::*;

	localparam int RESET_CYCLES = 3;
	localparam int FILL_CYCLES  = RAM_WORDS / 2;
	localparam int NUM_OPS      = 1900;
	// Run length plus slack for the drain cycles
	localparam int MAX_CYCLES   = RESET_CYCLES + FILL_CYCLES + NUM_OPS + 80;

	logic                clk = 1'b0;
	logic                reset;
	core_req_t           req;
	con_req_t            con;
	io_in_t              io_in;
	logic [31:0]         ld_data;
	logic                ld_valid;
	logic [31:0]         con_rdata;
	logic [LED_PINS-1:0] led;

	integer seed = 252;
	int     cycle_count = 0;
	int     step_count = 0;

	// Reference model state
	logic [31:0] ram_model [0:RAM_WORDS-1];
	logic [31:0] led_model;
	logic [3:0]  samp_btn;
	logic [2:0]  samp_sw;
	logic        con_armed;

	// Expected outputs for the cycle after the current request
	logic                exp_ld_valid;
	logic [31:0]         exp_ld_data;
	logic                exp_con_check;
	logic [31:0]         exp_con_rdata;
	logic [LED_PINS-1:0] exp_led;

	int ld_data_errs = 0;
	int ld_valid_errs = 0;
	int con_errs = 0;
	int led_errs = 0;

	core_req_t stim_req;
	con_req_t  stim_con;

	mem_subsys dut0 (
		.clk       (clk),
		.reset     (reset),
		.req       (req),
		.con       (con),
		.io_in     (io_in),
		.ld_data   (ld_data),
		.ld_valid  (ld_valid),
		.con_rdata (con_rdata),
		.led       (led)
	);

	always #20 clk = ~clk;

	// Run limit
	always @(posedge clk) begin
		cycle_count = cycle_count + 1;
		if (cycle_count >= MAX_CYCLES) begin
			$display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display("Testbench failed");
			$finish;
		end
	end

	task automatic next_rand(output logic [31:0] v);
		v = $random(seed);
	endtask

	function automatic logic is_load(input mem_op_e op);
		return op inside {MEM_LB, MEM_LBU, MEM_LH, MEM_LHU, MEM_LW};
	endfunction

	function automatic logic is_store(input mem_op_e op);
		return op inside {MEM_SB, MEM_SH, MEM_SW};
	endfunction

	// Distinct word for every RAM address
	function automatic logic [31:0] fill_value(input int a);
		return 32'h5A3C0000 ^ (32'(a) * 32'h9E3779B1);
	endfunction

	// Load result from a whole word, sub-size address bits ignored
	function automatic logic [31:0] load_value(input mem_op_e op, input logic [1:0] off,
			input logic [31:0] w);
		logic [7:0]  b;
		logic [15:0] h;
		b = 8'(w >> (8 * off));
		h = 16'(w >> (16 * off[1]));
		case (op)
			MEM_LB:  return 32'($signed(b));
			MEM_LBU: return 32'(b);
			MEM_LH:  return 32'($signed(h));
			MEM_LHU: return 32'(h);
			MEM_LW:  return w;
			default: return 32'h00000000;
		endcase
	endfunction

	// Store merged by bit mask
	function automatic logic [31:0] merge_store(input mem_op_e op, input logic [1:0] off,
			input logic [31:0] old, input logic [31:0] val);
		logic [31:0] mask;
		logic [31:0] shifted;
		mask = 32'h00000000;
		shifted = val;
		case (op)
			MEM_SB: begin
				mask = 32'h000000FF << (8 * off);
				shifted = val << (8 * off);
			end
			MEM_SH: begin
				mask = 32'h0000FFFF << (16 * off[1]);
				shifted = val << (16 * off[1]);
			end
			MEM_SW: mask = 32'hFFFFFFFF;
			default: mask = 32'h00000000;
		endcase
		return (old & ~mask) | (shifted & mask);
	endfunction

	// Controller raw lane mask
	function automatic logic [31:0] lane_merge(input logic [31:0] old, input logic [31:0] data,
			input logic [3:0] lanes);
		logic [31:0] res;
		res = old;
		for (int i = 0; i < 4; i++) begin
			if (lanes[i])
				res[i*8 +: 8] = data[i*8 +: 8];
		end
		return res;
	endfunction

	task automatic ld_data_compare(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			ld_data_errs++;
			$display("Mismatch at %0t: ld_data is %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic ld_valid_compare(input logic got, input logic exp);
		if (got !== exp) begin
			ld_valid_errs++;
			$display("Mismatch at %0t: ld_valid is %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic con_rdata_compare(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			con_errs++;
			$display("Mismatch at %0t: con_rdata is %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic led_compare(input logic [LED_PINS-1:0] got, input logic [LED_PINS-1:0] exp);
		if (got !== exp) begin
			led_errs++;
			$display("Mismatch at %0t: led is %b, expected %b", $time, got, exp);
		end
	endtask

	task automatic check_outputs();
		ld_valid_compare(ld_valid, exp_ld_valid);
		if (exp_ld_valid)
			ld_data_compare(ld_data, exp_ld_data);
		if (exp_con_check)
			con_rdata_compare(con_rdata, exp_con_rdata);
		led_compare(led, exp_led);
	endtask

	// One cycle: check last results, drive new request, predict its results
	task automatic run_cycle(input core_req_t r, input con_req_t c);
		logic [10:0] word;
		logic [1:0]  off;
		logic [31:0] cur;
		logic [31:0] rnd;
		@(negedge clk);
		check_outputs();
		req = r;
		con = c;
		// New board inputs every 16 cycles
		if (step_count % 16 == 15) begin
			next_rand(rnd);
			io_in = io_in_t'(rnd[6:0]);
		end
		word = r.addr[12:2];
		off = r.addr[1:0];
		// Old contents, before any write of this cycle
		if (word < RAM_WORDS)
			cur = ram_model[word[9:0]];
		else if (word == IO_BTN_WORD)
			cur = 32'(samp_btn);
		else if (word == IO_SW_WORD)
			cur = 32'(samp_sw);
		else if (word == IO_LED_WORD)
			cur = led_model;
		else
			cur = 32'h00000000;
		exp_ld_valid = is_load(r.op);
		exp_ld_data = load_value(r.op, off, cur);
		exp_con_check = con_armed;
		exp_con_rdata = ram_model[c.addr];
		// Writes take effect at the closing edge
		if (is_store(r.op)) begin
			if (word < RAM_WORDS)
				ram_model[word[9:0]] = merge_store(r.op, off, ram_model[word[9:0]], r.wdata);
			else if (word == IO_LED_WORD)
				led_model = merge_store(r.op, off, led_model, r.wdata);
		end
		ram_model[c.addr] = lane_merge(ram_model[c.addr], c.data, c.lanes);
		exp_led = led_model[LED_PINS-1:0];
		samp_btn = io_in.btn;
		samp_sw = io_in.sw;
		step_count++;
	endtask

	task automatic build_random(output core_req_t r, output con_req_t c);
		logic [31:0] rnd;
		logic [10:0] word;
		next_rand(rnd);
		r.op = mem_op_e'(4'(rnd % 9));
		next_rand(rnd);
		// Mostly a small window so both ports meet on the same words
		case (rnd[2:0])
			3'd0: word = IO_BTN_WORD + 11'(rnd[4:3] % 3);
			3'd1: word = 11'(rnd[13:4]);
			default: word = 11'(rnd[7:4]);
		endcase
		r.addr = {word, rnd[15:14]};
		next_rand(rnd);
		r.wdata = rnd;
		next_rand(rnd);
		c.addr = rnd[14] ? rnd[13:4] : 10'(rnd[3:0]);
		c.lanes = rnd[15] ? rnd[19:16] : 4'b0000;
		next_rand(rnd);
		c.data = rnd;
		// No same-word writes from both ports in one cycle
		if (is_store(r.op) && word < RAM_WORDS && word[9:0] == c.addr)
			c.lanes = 4'b0000;
	endtask

	initial begin
		reset = 1'b1;
		req = '0;
		con = '0;
		io_in = '0;
		led_model = 32'h00000000;
		samp_btn = 4'h0;
		samp_sw = 3'h0;
		con_armed = 1'b0;
		exp_ld_valid = 1'b0;
		exp_ld_data = 32'h00000000;
		exp_con_check = 1'b0;
		exp_con_rdata = 32'h00000000;
		exp_led = '0;
		repeat (RESET_CYCLES) @(negedge clk);
		reset = 1'b0;

		// Fill, core on the low half and controller on the high half
		for (int i = 0; i < FILL_CYCLES; i++) begin
			stim_req.op = MEM_SW;
			stim_req.addr = {11'(i), 2'b00};
			stim_req.wdata = fill_value(i);
			stim_con.lanes = 4'b1111;
			stim_con.addr = 10'(i + FILL_CYCLES);
			stim_con.data = fill_value(i + FILL_CYCLES);
			run_cycle(stim_req, stim_con);
		end
		con_armed = 1'b1;

		for (int n = 0; n < NUM_OPS; n++) begin
			build_random(stim_req, stim_con);
			run_cycle(stim_req, stim_con);
		end

		// Idle cycle, then collect the last results
		run_cycle('0, '0);
		@(negedge clk);
		check_outputs();

		$display("Errors: ld_data %0d, ld_valid %0d, con_rdata %0d, led %0d",
			ld_data_errs, ld_valid_errs, con_errs, led_errs);
		if (ld_data_errs + ld_valid_errs + con_errs + led_errs == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== list.f ====
verilog/mem_pkg.sv
verilog/byte_ram.sv
verilog/io_regs.sv
verilog/lsu_align.sv
verilog/datamem.sv
verilog/mem_subsys.sv
sim/mem_subsys_chk.sv
sim/mem_subsys_tb.sv
